/* Bender.yml */
package:
  name: div

sources:
  - common/div_pkg.sv
  - div_array/div_radix4_stage.sv
  - div_array/div_stage_array.sv
  - source/div_operand_prep.sv
  - source/div_result_fix.sv
  - source/div_top.sv
  - target: test
    files:
      - verification/div_properties.sv
      - verification/div_checker.sv
      - verification/div_tb.sv

/* all.f */
common/div_pkg.sv
div_array/div_radix4_stage.sv
div_array/div_stage_array.sv
source/div_operand_prep.sv
source/div_result_fix.sv
source/div_top.sv
verification/div_properties.sv
verification/div_checker.sv
verification/div_tb.sv

/* common/div_pkg.sv */
`default_nettype none

package div_pkg;

  // ------------------------------
  // sizes.
  // ------------------------------
  localparam int DATA_W  = 32;
  localparam int STAGES  = DATA_W / 2;   // two quotient bits per step.
  localparam int LATENCY = STAGES + 2;   // prep + array + output register.

  localparam logic [DATA_W-1:0] INT_MIN = {1'b1, {(DATA_W-1){1'b0}}};

  // ------------------------------
  // opcodes.
  // ------------------------------
  localparam logic [1:0] OP_DIV  = 2'd0;
  localparam logic [1:0] OP_DIVU = 2'd1;
  localparam logic [1:0] OP_REM  = 2'd2;
  localparam logic [1:0] OP_REMU = 2'd3;

  typedef union packed {
    logic [1:0] code;
    struct packed {
      logic rem;    // result is the remainder.
      logic unsgn;  // operands are unsigned.
    } bits;
  } div_op_u;

  // ------------------------------
  // pipeline groups.
  // ------------------------------
  typedef struct packed {
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    div_op_u           op;
  } div_req_t;

  typedef struct packed {
    div_op_u op;
    logic    a_neg;     // remainder gets negated.
    logic    q_neg;     // quotient gets negated.
    logic    div_zero;
    logic    overflow;
  } div_ctl_t;

  typedef struct packed {
    logic [DATA_W+1:0] rem;   // partial remainder.
    logic [DATA_W-1:0] quo;   // dividend bits out on the left, quotient bits in on the right.
    logic [DATA_W-1:0] dvs;
    logic [DATA_W+1:0] dvs3;
  } div_stage_t;

endpackage

`default_nettype wire

/* div_array/div_radix4_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module div_radix4_stage (
  input  wire                 CLK,
  input  wire                 stall,
  input  div_pkg::div_stage_t in,
  output div_pkg::div_stage_t out
);

  // one spare bit on top carries the sign of each trial.
  logic [div_pkg::DATA_W+2:0] sh;
  logic [div_pkg::DATA_W+2:0] d1;
  logic [div_pkg::DATA_W+2:0] d2;
  logic [div_pkg::DATA_W+2:0] d3;
  logic [1:0]                 digit;
  div_pkg::div_stage_t        nxt;

  assign sh = {1'b0, in.rem[div_pkg::DATA_W-1:0], in.quo[div_pkg::DATA_W-1 -: 2]};
  assign d1 = sh - {3'b000, in.dvs};
  assign d2 = sh - {2'b00, in.dvs, 1'b0};
  assign d3 = sh - {1'b0, in.dvs3};

  // restoring step, largest multiple that still fits.
  always_comb begin
    nxt = in;
    if (!d3[div_pkg::DATA_W+2]) begin
      nxt.rem = d3[div_pkg::DATA_W+1:0];
      digit   = 2'd3;
    end else if (!d2[div_pkg::DATA_W+2]) begin
      nxt.rem = d2[div_pkg::DATA_W+1:0];
      digit   = 2'd2;
    end else if (!d1[div_pkg::DATA_W+2]) begin
      nxt.rem = d1[div_pkg::DATA_W+1:0];
      digit   = 2'd1;
    end else begin
      nxt.rem = sh[div_pkg::DATA_W+1:0];
      digit   = 2'd0;
    end
    nxt.quo = {in.quo[div_pkg::DATA_W-3:0], digit};
  end

  always_ff @(posedge CLK) begin
    if (!stall) begin
      out <= nxt;
    end
  end

endmodule

`default_nettype wire

/* div_array/div_stage_array.sv */
`timescale 1ns/1ps
`default_nettype none

module div_stage_array (
  input  wire                 CLK,
  input  wire                 RST_N,
  input  wire                 stall,
  input  div_pkg::div_stage_t data_in,
  input  div_pkg::div_ctl_t   ctl_in,
  input  wire                 valid_in,
  output div_pkg::div_stage_t data_out,
  output div_pkg::div_ctl_t   ctl_out,
  output logic                valid_out
);

  div_pkg::div_stage_t          stage_d [0:div_pkg::STAGES];
  div_pkg::div_ctl_t            ctl_q   [0:div_pkg::STAGES-1];
  logic [div_pkg::STAGES-1:0]   valid_q;

  // ------------------------------
  // datapath.
  // ------------------------------
  assign stage_d[0] = data_in;

  for (genvar g = 0; g < div_pkg::STAGES; g++) begin : g_stage
    div_radix4_stage u_stage (
      .CLK   (CLK),
      .stall (stall),
      .in    (stage_d[g]),
      .out   (stage_d[g+1])
    );
  end

  assign data_out = stage_d[div_pkg::STAGES];

  // ------------------------------
  // sideband, in step with the data.
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (!stall) begin
      ctl_q[0] <= ctl_in;
      for (int i = 1; i < div_pkg::STAGES; i++) begin
        ctl_q[i] <= ctl_q[i-1];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      valid_q <= '0;
    end else if (!stall) begin
      valid_q <= {valid_q[div_pkg::STAGES-2:0], valid_in};
    end
  end

  assign ctl_out   = ctl_q[div_pkg::STAGES-1];
  assign valid_out = valid_q[div_pkg::STAGES-1];

endmodule

`default_nettype wire

/* source/div_operand_prep.sv */
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep (
  input  wire                 CLK,
  input  wire                 RST_N,
  input  div_pkg::div_req_t   req,
  input  wire                 req_valid,
  input  wire                 stall,
  input  wire                 req_ready,
  output div_pkg::div_stage_t data,
  output div_pkg::div_ctl_t   ctl,
  output logic                valid
);

  logic                       accept;
  logic                       sgn;
  logic                       a_neg;
  logic                       b_neg;
  logic [div_pkg::DATA_W-1:0] a_mag;
  logic [div_pkg::DATA_W-1:0] b_mag;

  assign accept = req_valid & req_ready;

  // signed ops look at the sign bits.
  assign sgn   = ~req.op.bits.unsgn;
  assign a_neg = sgn & req.a[div_pkg::DATA_W-1];
  assign b_neg = sgn & req.b[div_pkg::DATA_W-1];
  assign a_mag = a_neg ? -req.a : req.a;  // INT_MIN maps to 2**31 unsigned.
  assign b_mag = b_neg ? -req.b : req.b;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      valid <= 1'b0;
    end else if (!stall) begin
      valid <= accept;
    end
  end

  // nothing is accepted under stall, so the stage holds.
  always_ff @(posedge CLK) begin
    if (accept) begin
      data.rem      <= '0;
      data.quo      <= a_mag;
      data.dvs      <= b_mag;
      data.dvs3     <= {2'b00, b_mag} + {1'b0, b_mag, 1'b0};
      ctl.op        <= req.op;
      ctl.a_neg     <= a_neg;
      ctl.q_neg     <= a_neg ^ b_neg;
      ctl.div_zero  <= (req.b == '0);
      ctl.overflow  <= sgn && (req.a == div_pkg::INT_MIN) && (req.b == '1);
    end
  end

endmodule

`default_nettype wire

/* source/div_result_fix.sv */
`timescale 1ns/1ps
`default_nettype none

module div_result_fix (
  input  wire                        CLK,
  input  wire                        RST_N,
  input  div_pkg::div_stage_t        data,
  input  div_pkg::div_ctl_t          ctl,
  input  wire                        valid,
  input  wire                        res_ready,
  output logic [div_pkg::DATA_W-1:0] res,
  output logic                       res_valid,
  output logic                       stall
);

  logic [div_pkg::DATA_W-1:0] q_mag;
  logic [div_pkg::DATA_W-1:0] r_mag;
  logic [div_pkg::DATA_W-1:0] res_d;

  assign q_mag = data.quo;
  assign r_mag = data.rem[div_pkg::DATA_W-1:0];

  // ------------------------------
  // sign fix and special cases.
  // ------------------------------
  always_comb begin
    if (ctl.overflow) begin
      // INT_MIN / -1.
      res_d = ctl.op.bits.rem ? '0 : div_pkg::INT_MIN;
    end else if (ctl.div_zero && !ctl.op.bits.rem) begin
      res_d = '1;
    end else if (ctl.op.bits.rem) begin
      // a zero divisor leaves the dividend magnitude in rem,
      // so REM by zero comes back as the dividend here.
      res_d = ctl.a_neg ? -r_mag : r_mag;
    end else begin
      res_d = ctl.q_neg ? -q_mag : q_mag;
    end
  end

  // ------------------------------
  // output register.
  // ------------------------------
  assign stall = ~RST_N | (res_valid & ~res_ready);  // freeze during reset too.

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      res_valid <= 1'b0;
    end else if (!stall) begin
      res_valid <= valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall) begin
      res <= res_d;
    end
  end

endmodule

`default_nettype wire

/* source/div_top.sv */
`timescale 1ns/1ps
`default_nettype none

module div_top (
  input  wire                  CLK,
  input  wire                  RST_N,
  input  div_pkg::div_req_t    req,
  input  wire                  req_valid,
  output logic                 req_ready,
  output logic [div_pkg::DATA_W-1:0] res,
  output logic                 res_valid,
  input  wire                  res_ready
);

  div_pkg::div_stage_t prep_data;
  div_pkg::div_ctl_t   prep_ctl;
  logic                prep_valid;
  div_pkg::div_stage_t arr_data;
  div_pkg::div_ctl_t   arr_ctl;
  logic                arr_valid;
  logic                stall;

  assign req_ready = ~stall;  // low through reset as well.

  div_operand_prep u_prep (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .req       (req),
    .req_valid (req_valid),
    .stall     (stall),
    .req_ready (req_ready),
    .data      (prep_data),
    .ctl       (prep_ctl),
    .valid     (prep_valid)
  );

  div_stage_array u_array (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .stall     (stall),
    .data_in   (prep_data),
    .ctl_in    (prep_ctl),
    .valid_in  (prep_valid),
    .data_out  (arr_data),
    .ctl_out   (arr_ctl),
    .valid_out (arr_valid)
  );

  div_result_fix u_fix (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .data      (arr_data),
    .ctl       (arr_ctl),
    .valid     (arr_valid),
    .res_ready (res_ready),
    .res       (res),
    .res_valid (res_valid),
    .stall     (stall)
  );

endmodule

`default_nettype wire

/* verification/div_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module div_checker (
  input  wire                       CLK,
  input  wire                       RST_N,
  input  wire [div_pkg::DATA_W-1:0] res,
  input  wire                       res_valid,
  input  wire                       res_ready,
  output int                        n_pass,
  output int                        n_fail,
  output int                        n_done
);

  logic [div_pkg::DATA_W-1:0] exp_q [$];
  int                         idx_q [$];
  logic [div_pkg::DATA_W-1:0] exp_v;
  int                         idx_v;

  initial begin
    n_pass = 0;
    n_fail = 0;
    n_done = 0;
  end

  // called by the testbench for each request that is taken.
  task automatic expect_result(input logic [div_pkg::DATA_W-1:0] value, input int idx);
    exp_q.push_back(value);
    idx_q.push_back(idx);
  endtask

  // mid-cycle, a valid and ready pair means a transfer at the next edge.
  always @(negedge CLK) begin
    if (RST_N && res_valid && res_ready) begin
      if (exp_q.size() == 0) begin
        $display("result %h arrived with no request pending", res);
        n_fail++;
      end else begin
        exp_v = exp_q.pop_front();
        idx_v = idx_q.pop_front();
        n_done++;
        if (res === exp_v) begin
          $display("test %0d ok: res %h", idx_v, res);
          n_pass++;
        end else begin
          $display("ERROR res test %0d: expected %h, got %h", idx_v, exp_v, res);
          n_fail++;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verification/div_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module div_properties (
  input wire                        CLK,
  input wire                        RST_N,
  input wire                        req_ready,
  input wire [div_pkg::DATA_W-1:0]  res,
  input wire                        res_valid,
  input wire                        res_ready
);

  int err_cnt;

  initial err_cnt = 0;

  // ------------------------------
  // result channel.
  // ------------------------------
  a_res_stable: assert property (@(posedge CLK) disable iff (!RST_N)
    res_valid && !res_ready |=> $stable(res))
    else begin
      $error("res changed while waiting for res_ready");
      err_cnt++;
    end

  a_valid_held: assert property (@(posedge CLK) disable iff (!RST_N)
    res_valid && !res_ready |=> res_valid)
    else begin
      $error("res_valid dropped without a transfer");
      err_cnt++;
    end

  // ------------------------------
  // reset.
  // ------------------------------
  a_reset_ready: assert property (@(posedge CLK) !RST_N |-> !req_ready)
    else begin
      $error("req_ready high during reset");
      err_cnt++;
    end

  a_reset_valid: assert property (@(posedge CLK) !RST_N |=> !res_valid)
    else begin
      $error("res_valid high after a reset cycle");
      err_cnt++;
    end

endmodule

bind div_top div_properties u_props (.*);

`default_nettype wire

/* verification/div_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module div_tb;

  logic                       CLK = 1'b0;
  logic                       RST_N;
  div_pkg::div_req_t          req;
  logic                       req_valid;
  logic                       req_ready;
  logic [div_pkg::DATA_W-1:0] res;
  logic                       res_valid;
  logic                       res_ready;

  logic [1:0]                 t_op  [0:63];
  logic [div_pkg::DATA_W-1:0] t_a   [0:63];
  logic [div_pkg::DATA_W-1:0] t_b   [0:63];
  logic [div_pkg::DATA_W-1:0] t_exp [0:63];
  logic [31:0]                f_op;
  logic [31:0]                f_a;
  logic [31:0]                f_b;
  logic [31:0]                f_e;
  logic [31:0]                lfsr = 32'h0667_6fd4;
  logic                       bit0;
  logic                       bit1;
  string                      line;
  int                         fd;
  int                         n_tests;
  int                         idx;
  int                         limit;
  int                         n_pass;
  int                         n_fail;
  int                         n_done;
  int                         cycles = 0;
  logic                       open_ok;
  logic                       timed_out;

  div_top u_dut (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  div_checker u_chk (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .n_pass    (n_pass),
    .n_fail    (n_fail),
    .n_done    (n_done)
  );

  always #2 CLK = ~CLK;

  always @(posedge CLK) cycles++;

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // res_ready low when both bits are zero, about a quarter of the time.
  always @(posedge CLK) begin
    #1;
    lfsr = lfsr_next(lfsr);
    bit0 = lfsr[0];
    lfsr = lfsr_next(lfsr);
    bit1 = lfsr[0];
    res_ready = bit0 | bit1;
  end

  initial begin
    RST_N = 1'b0;
    req = '0;
    req_valid = 1'b0;
    res_ready = 1'b0;
    n_tests = 0;
    timed_out = 1'b0;
    fd = $fopen("verification/div_tests.txt", "r");
    open_ok = (fd != 0);
    if (!open_ok) begin
      $display("cannot open the test file");
    end else begin
      while (!$feof(fd) && n_tests < 64) begin
        line = "";
        if ($fgets(line, fd) > 0 &&
            $sscanf(line, "%h %h %h %h", f_op, f_a, f_b, f_e) == 4) begin
          t_op[n_tests]  = f_op[1:0];
          t_a[n_tests]   = f_a;
          t_b[n_tests]   = f_b;
          t_exp[n_tests] = f_e;
          n_tests++;
        end
      end
      $fclose(fd);
    end
    limit = n_tests * (div_pkg::LATENCY + 8) + 100;

    repeat (8) @(posedge CLK);
    #1 RST_N = 1'b1;

    // idle after reset, nothing may come out before the first request.
    repeat (div_pkg::LATENCY) @(posedge CLK);
    #1;

    // ------------------------------
    // back-to-back requests.
    // ------------------------------
    idx = 0;
    while (idx < n_tests && cycles < limit) begin
      req.a       = t_a[idx];
      req.b       = t_b[idx];
      req.op.code = t_op[idx];
      req_valid   = 1'b1;
      @(negedge CLK);
      if (req_ready) begin
        u_chk.expect_result(t_exp[idx], idx);
        idx++;
      end
      @(posedge CLK);
      #1;
    end
    req_valid = 1'b0;

    while (n_done < n_tests && cycles < limit) @(posedge CLK);
    if (n_done < n_tests) begin
      $display("timeout: results missing");
      timed_out = 1'b1;
    end
    repeat (div_pkg::LATENCY + 4) @(posedge CLK);  // catch stray results.

    $display("tests %0d, passed %0d, failed %0d, assertion errors %0d",
             n_tests, n_pass, n_fail, u_dut.u_props.err_cnt);
    if (open_ok && !timed_out && n_tests > 0 && n_fail == 0 && n_pass == n_tests &&
        u_dut.u_props.err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/div_tests.txt */
# op dividend divisor expected, all hex.
# op: 0 DIV, 1 DIVU, 2 REM, 3 REMU.
1 00000064 00000007 0000000e
3 00000064 00000007 00000002
1 00000005 00000009 00000000
3 00000005 00000009 00000005
1 ffffffff 00000001 ffffffff
3 ffffffff 00000001 00000000
1 80000000 00000003 2aaaaaaa
3 80000000 00000003 00000002
1 deadbeef 00001000 000deadb
3 deadbeef 00001000 00000eef
0 00000007 00000002 00000003
0 fffffff9 00000002 fffffffd
0 00000007 fffffffe fffffffd
0 fffffff9 fffffffe 00000003
2 00000007 00000002 00000001
2 fffffff9 00000002 ffffffff
2 00000007 fffffffe 00000001
2 fffffff9 fffffffe ffffffff
0 80000000 00000002 c0000000
0 00001234 00000000 ffffffff
1 00001234 00000000 ffffffff
2 fffffff9 00000000 fffffff9
3 00001234 00000000 00001234
0 80000000 ffffffff 80000000
2 80000000 ffffffff 00000000
